// ==== design/flash_emu_pkg.sv ====
package flash_emu_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////////////////////////

	// flash byte address as seen on the spi bus
	localparam int ADDR_W = 24;
	// index into the on-chip store
	localparam int MEM_AW = 12;
	// store depth, addresses wrap modulo this
	localparam int MEM_DEPTH = 1 << MEM_AW;
	localparam int BYTE_W = 8;
	// logged length, saturates at all ones
	localparam int LEN_W = 8;

	//////////////////////////////////////////////////////////////////////
	// spi flash commands and identity
	//////////////////////////////////////////////////////////////////////

	// normal read, followed by three address bytes
	localparam logic [BYTE_W-1:0] CMD_READ = 8'h03;
	// read jedec id, no address
	localparam logic [BYTE_W-1:0] CMD_READ_ID = 8'h9f;
	// manufacturer, memory type, capacity; sent msb first
	localparam logic [ADDR_W-1:0] JEDEC_ID = 24'h5a4018;

	//////////////////////////////////////////////////////////////////////
	// log output
	//////////////////////////////////////////////////////////////////////

	// clk cycles per serial bit
	localparam int BAUD_DIV = 8;
	// three address bytes and one length byte
	localparam int LOG_BYTES = 4;

endpackage

// ==== design/spi_device.sv ====
`timescale 1ns/1ps

module spi_device (
	input  logic clk,
	input  logic reset,
	// raw pins from the host spi master
	input  logic spi_cs_n_i,
	input  logic spi_sck_i,
	input  logic spi_mosi_i,
	output logic spi_miso_o,
	output logic spi_miso_oe_o,
	// byte side, all in clk
	output logic [flash_emu_pkg::BYTE_W-1:0] rx_data_o,
	output logic rx_strobe_o,
	output logic rx_cmd_o,
	output logic cs_active_o,
	input  logic [flash_emu_pkg::BYTE_W-1:0] tx_data_i,
	output logic tx_strobe_o,
	input  logic miso_en_i
);
	// two stage synchronizers, index 1 is the safe one
	logic [1:0] cs_sync;
	logic [1:0] sck_sync;
	logic [1:0] mosi_sync;
	// previous synchronized sck for edge detect
	logic sck_prev;
	logic sck_rise;
	logic sck_fall;
	// bit position within the current byte
	logic [$clog2(flash_emu_pkg::BYTE_W)-1:0] bit_cnt;
	// set until the first byte after chip select falls is complete
	logic first_byte;
	logic [flash_emu_pkg::BYTE_W-1:0] rx_shift;
	logic [flash_emu_pkg::BYTE_W-1:0] tx_shift;

	assign cs_active_o = !cs_sync[1];
	// edges only count while selected
	assign sck_rise = sck_sync[1] && !sck_prev && cs_active_o;
	assign sck_fall = !sck_sync[1] && sck_prev && cs_active_o;

	// mode 0, msb first out of the shift register
	assign spi_miso_o = tx_shift[flash_emu_pkg::BYTE_W-1];
	assign spi_miso_oe_o = cs_active_o && miso_en_i;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cs_sync <= 2'b11;
			sck_sync <= 2'b00;
			sck_prev <= 1'b0;
			bit_cnt <= '0;
			first_byte <= 1'b1;
			rx_strobe_o <= 1'b0;
			rx_cmd_o <= 1'b0;
			tx_strobe_o <= 1'b0;
		end
		else
		begin
			cs_sync <= {cs_sync[0], spi_cs_n_i};
			sck_sync <= {sck_sync[0], spi_sck_i};
			sck_prev <= sck_sync[1];
			rx_strobe_o <= 1'b0;
			tx_strobe_o <= 1'b0;

			if (!cs_active_o)
			begin
				// deselected, next byte is a command again
				bit_cnt <= '0;
				first_byte <= 1'b1;
			end
			else if (sck_rise)
			begin
				bit_cnt <= bit_cnt + 1'b1;
				if (&bit_cnt)
				begin
					// eighth bit in, hand the byte over
					rx_strobe_o <= 1'b1;
					rx_cmd_o <= first_byte;
					first_byte <= 1'b0;
				end
			end
			// the falling edge at a byte boundary loads the next tx byte
			else if (sck_fall && bit_cnt == '0)
				tx_strobe_o <= 1'b1;
		end
	end

	// shift registers and received data
	always_ff @(posedge clk)
	begin
		mosi_sync <= {mosi_sync[0], spi_mosi_i};
		if (sck_rise)
		begin
			rx_shift <= {rx_shift[flash_emu_pkg::BYTE_W-2:0], mosi_sync[1]};
			if (&bit_cnt)
				rx_data_o <= {rx_shift[flash_emu_pkg::BYTE_W-2:0], mosi_sync[1]};
		end
		if (sck_fall)
		begin
			if (bit_cnt == '0)
				tx_shift <= tx_data_i;
			else
				tx_shift <= {tx_shift[flash_emu_pkg::BYTE_W-2:0], 1'b0};
		end
	end

endmodule

// ==== design/spi_flash.sv ====
`timescale 1ns/1ps

module spi_flash (
	input  logic clk,
	input  logic reset,
	// byte interface from spi_device
	input  logic [flash_emu_pkg::BYTE_W-1:0] rx_data_i,
	input  logic rx_strobe_i,
	input  logic rx_cmd_i,
	input  logic cs_active_i,
	output logic [flash_emu_pkg::BYTE_W-1:0] tx_data_o,
	input  logic tx_strobe_i,
	output logic miso_en_o,
	// store read port
	output logic spi_critical_o,
	output logic rd_en_o,
	output logic [flash_emu_pkg::MEM_AW-1:0] rd_addr_o,
	input  logic [flash_emu_pkg::BYTE_W-1:0] rd_data_i,
	input  logic rd_ack_i,
	// log record
	output logic log_strobe_o,
	output logic [flash_emu_pkg::ADDR_W-1:0] log_addr_o,
	output logic [flash_emu_pkg::LEN_W-1:0] log_len_o
);
	typedef enum logic [2:0] {
		ST_CMD,
		ST_ADDR0,
		ST_ADDR1,
		ST_ADDR2,
		ST_DATA,
		ST_ID,
		ST_IGNORE
	} state_t;

	state_t state;
	logic cs_prev;
	// which id byte goes out next, 3 means past the end
	logic [1:0] id_idx;
	logic [flash_emu_pkg::BYTE_W-1:0] id_byte;
	// address of the byte after the one being prefetched
	logic [flash_emu_pkg::MEM_AW-1:0] next_addr;
	// address with the newest byte shifted in
	logic [flash_emu_pkg::ADDR_W-1:0] addr_full;

	assign addr_full = {log_addr_o[flash_emu_pkg::ADDR_W-flash_emu_pkg::BYTE_W-1:0], rx_data_i};

	// miso only driven while we have something to say
	assign miso_en_o = (state == ST_DATA) || (state == ST_ID);

	always_comb
	begin
		case (id_idx)
			2'd0: id_byte = flash_emu_pkg::JEDEC_ID[23:16];
			2'd1: id_byte = flash_emu_pkg::JEDEC_ID[15:8];
			2'd2: id_byte = flash_emu_pkg::JEDEC_ID[7:0];
			default: id_byte = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// phase machine
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= ST_CMD;
			cs_prev <= 1'b0;
			id_idx <= '0;
			spi_critical_o <= 1'b0;
			rd_en_o <= 1'b0;
			log_strobe_o <= 1'b0;
			log_len_o <= '0;
		end
		else
		begin
			cs_prev <= cs_active_i;
			// store belongs to spi for the whole transaction
			spi_critical_o <= cs_active_i;
			rd_en_o <= 1'b0;
			log_strobe_o <= 1'b0;

			if (!cs_active_i)
			begin
				state <= ST_CMD;
				// log only reads that got past the address
				if (cs_prev && state == ST_DATA)
					log_strobe_o <= 1'b1;
			end
			else if (rx_strobe_i && rx_cmd_i)
			begin
				case (rx_data_i)
					flash_emu_pkg::CMD_READ:
						state <= ST_ADDR0;
					flash_emu_pkg::CMD_READ_ID:
					begin
						state <= ST_ID;
						id_idx <= '0;
					end
					default:
						state <= ST_IGNORE;
				endcase
			end
			else if (rx_strobe_i)
			begin
				case (state)
					ST_ADDR0: state <= ST_ADDR1;
					ST_ADDR1: state <= ST_ADDR2;
					ST_ADDR2:
					begin
						// address complete, fetch first byte now
						state <= ST_DATA;
						rd_en_o <= 1'b1;
						log_len_o <= '0;
					end
					ST_DATA:
						if (log_len_o != {flash_emu_pkg::LEN_W{1'b1}})
							log_len_o <= log_len_o + 1'b1;
					default: ;
				endcase
			end
			else if (tx_strobe_i)
			begin
				// byte just left for the shifter, fetch the next one
				if (state == ST_DATA)
					rd_en_o <= 1'b1;
				if (state == ST_ID && id_idx != 2'd3)
					id_idx <= id_idx + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// address and prefetch registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rx_strobe_i && !rx_cmd_i && cs_active_i &&
			(state == ST_ADDR0 || state == ST_ADDR1 || state == ST_ADDR2))
		begin
			// address arrives msb first
			log_addr_o <= addr_full;
			if (state == ST_ADDR2)
			begin
				rd_addr_o <= addr_full[flash_emu_pkg::MEM_AW-1:0];
				next_addr <= addr_full[flash_emu_pkg::MEM_AW-1:0] + 1'b1;
			end
		end
		else if (tx_strobe_i && state == ST_DATA)
		begin
			// wraps modulo store depth
			rd_addr_o <= next_addr;
			next_addr <= next_addr + 1'b1;
		end

		if (rd_ack_i)
			tx_data_o <= rd_data_i;
		else if (state == ST_ID)
			tx_data_o <= id_byte;
	end

endmodule

// ==== design/flash_mem.sv ====
`timescale 1ns/1ps

module flash_mem (
	input  logic clk,
	input  logic reset,
	// spi side, always wins
	input  logic rd_en_i,
	input  logic [flash_emu_pkg::MEM_AW-1:0] rd_addr_i,
	output logic [flash_emu_pkg::BYTE_W-1:0] rd_data_o,
	output logic rd_ack_o,
	input  logic spi_critical_i,
	// host preload port
	input  logic load_we_i,
	input  logic [flash_emu_pkg::MEM_AW-1:0] load_addr_i,
	input  logic [flash_emu_pkg::BYTE_W-1:0] load_data_i,
	output logic load_ready_o
);
	logic [flash_emu_pkg::BYTE_W-1:0] mem [flash_emu_pkg::MEM_DEPTH];
	logic load_accept;

	// host waits out any spi transaction
	assign load_ready_o = !spi_critical_i && !rd_en_i;
	assign load_accept = load_we_i && load_ready_o;

	//////////////////////////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rd_en_i)
			rd_data_o <= mem[rd_addr_i];
		if (load_accept)
			mem[load_addr_i] <= load_data_i;
	end

	// data is ready one cycle after the request
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			rd_ack_o <= 1'b0;
		else
			rd_ack_o <= rd_en_i;
	end

endmodule

// ==== design/log_serializer.sv ====
`timescale 1ns/1ps

module log_serializer (
	input  logic clk,
	input  logic reset,
	// record from spi_flash
	input  logic log_strobe_i,
	input  logic [flash_emu_pkg::ADDR_W-1:0] log_addr_i,
	input  logic [flash_emu_pkg::LEN_W-1:0] log_len_i,
	// to the uart
	output logic [flash_emu_pkg::BYTE_W-1:0] tx_byte_o,
	output logic tx_start_o,
	input  logic tx_busy_i,
	output logic [flash_emu_pkg::BYTE_W-1:0] drop_count_o
);
	// latched record, next byte at the top
	logic [flash_emu_pkg::LOG_BYTES*flash_emu_pkg::BYTE_W-1:0] rec;
	// one bit per byte still to send
	logic [flash_emu_pkg::LOG_BYTES-1:0] pending;
	logic record_busy;
	logic send;

	// tx_start_o covers the cycle before the uart raises busy
	assign record_busy = (|pending) || tx_busy_i || tx_start_o;
	assign send = (|pending) && !tx_busy_i && !tx_start_o;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			pending <= '0;
			tx_start_o <= 1'b0;
			drop_count_o <= '0;
		end
		else
		begin
			tx_start_o <= send;
			if (log_strobe_i && !record_busy)
				pending <= '1;
			else if (send)
				pending <= pending >> 1;

			// refused record, count saturates
			if (log_strobe_i && record_busy && drop_count_o != {flash_emu_pkg::BYTE_W{1'b1}})
				drop_count_o <= drop_count_o + 1'b1;
		end
	end

	// address high to low, then length
	always_ff @(posedge clk)
	begin
		if (log_strobe_i && !record_busy)
			rec <= {log_addr_i, log_len_i};
		else if (send)
		begin
			tx_byte_o <= rec[$bits(rec)-1 -: flash_emu_pkg::BYTE_W];
			rec <= rec << flash_emu_pkg::BYTE_W;
		end
	end

endmodule

// ==== design/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
	input  logic clk,
	input  logic reset,
	input  logic [flash_emu_pkg::BYTE_W-1:0] tx_byte_i,
	input  logic tx_start_i,
	output logic busy_o,
	output logic serial_o
);
	// data bits then stop bit, lsb goes out first
	logic [flash_emu_pkg::BYTE_W:0] shift;
	logic [$clog2(flash_emu_pkg::BAUD_DIV)-1:0] div_cnt;
	// 0 is the start bit, BYTE_W+1 the stop bit
	logic [$clog2(flash_emu_pkg::BYTE_W+2)-1:0] bit_cnt;
	logic bit_end;

	assign bit_end = (div_cnt == flash_emu_pkg::BAUD_DIV - 1);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			busy_o <= 1'b0;
			serial_o <= 1'b1;
			div_cnt <= '0;
			bit_cnt <= '0;
		end
		else if (!busy_o)
		begin
			if (tx_start_i)
			begin
				// start bit
				busy_o <= 1'b1;
				serial_o <= 1'b0;
				div_cnt <= '0;
				bit_cnt <= '0;
			end
		end
		else if (!bit_end)
			div_cnt <= div_cnt + 1'b1;
		else
		begin
			div_cnt <= '0;
			// stop bit finished, line already idle high
			if (bit_cnt == flash_emu_pkg::BYTE_W + 1)
				busy_o <= 1'b0;
			else
			begin
				serial_o <= shift[0];
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (tx_start_i && !busy_o)
			shift <= {1'b1, tx_byte_i};
		else if (busy_o && bit_end)
			shift <= {1'b1, shift[flash_emu_pkg::BYTE_W:1]};
	end

endmodule

// ==== design/flash_emu_top.sv ====
`timescale 1ns/1ps

module flash_emu_top (
	input  logic clk,
	input  logic reset,
	// spi pins, already in clk
	input  logic spi_cs_n_i,
	input  logic spi_sck_i,
	input  logic spi_mosi_i,
	output logic spi_miso_o,
	output logic spi_miso_oe_o,
	// store preload
	input  logic load_we_i,
	input  logic [flash_emu_pkg::MEM_AW-1:0] load_addr_i,
	input  logic [flash_emu_pkg::BYTE_W-1:0] load_data_i,
	output logic load_ready_o,
	// log output
	output logic serial_o,
	output logic [flash_emu_pkg::BYTE_W-1:0] drop_count_o
);
	// spi byte interface
	logic [flash_emu_pkg::BYTE_W-1:0] rx_data;
	logic rx_strobe;
	logic rx_cmd;
	logic cs_active;
	logic [flash_emu_pkg::BYTE_W-1:0] tx_data;
	logic tx_strobe;
	logic miso_en;

	// store read port
	logic spi_critical;
	logic rd_en;
	logic [flash_emu_pkg::MEM_AW-1:0] rd_addr;
	logic [flash_emu_pkg::BYTE_W-1:0] rd_data;
	logic rd_ack;

	// logging path
	logic log_strobe;
	logic [flash_emu_pkg::ADDR_W-1:0] log_addr;
	logic [flash_emu_pkg::LEN_W-1:0] log_len;
	logic [flash_emu_pkg::BYTE_W-1:0] tx_byte;
	logic tx_start;
	logic tx_busy;

	spi_device u_spi_device (
		.clk(clk),
		.reset(reset),
		.spi_cs_n_i(spi_cs_n_i),
		.spi_sck_i(spi_sck_i),
		.spi_mosi_i(spi_mosi_i),
		.spi_miso_o(spi_miso_o),
		.spi_miso_oe_o(spi_miso_oe_o),
		.rx_data_o(rx_data),
		.rx_strobe_o(rx_strobe),
		.rx_cmd_o(rx_cmd),
		.cs_active_o(cs_active),
		.tx_data_i(tx_data),
		.tx_strobe_o(tx_strobe),
		.miso_en_i(miso_en)
	);

	spi_flash u_spi_flash (
		.clk(clk),
		.reset(reset),
		.rx_data_i(rx_data),
		.rx_strobe_i(rx_strobe),
		.rx_cmd_i(rx_cmd),
		.cs_active_i(cs_active),
		.tx_data_o(tx_data),
		.tx_strobe_i(tx_strobe),
		.miso_en_o(miso_en),
		.spi_critical_o(spi_critical),
		.rd_en_o(rd_en),
		.rd_addr_o(rd_addr),
		.rd_data_i(rd_data),
		.rd_ack_i(rd_ack),
		.log_strobe_o(log_strobe),
		.log_addr_o(log_addr),
		.log_len_o(log_len)
	);

	flash_mem u_flash_mem (
		.clk(clk),
		.reset(reset),
		.rd_en_i(rd_en),
		.rd_addr_i(rd_addr),
		.rd_data_o(rd_data),
		.rd_ack_o(rd_ack),
		.spi_critical_i(spi_critical),
		.load_we_i(load_we_i),
		.load_addr_i(load_addr_i),
		.load_data_i(load_data_i),
		.load_ready_o(load_ready_o)
	);

	log_serializer u_log_serializer (
		.clk(clk),
		.reset(reset),
		.log_strobe_i(log_strobe),
		.log_addr_i(log_addr),
		.log_len_i(log_len),
		.tx_byte_o(tx_byte),
		.tx_start_o(tx_start),
		.tx_busy_i(tx_busy),
		.drop_count_o(drop_count_o)
	);

	uart_tx u_uart_tx (
		.clk(clk),
		.reset(reset),
		.tx_byte_i(tx_byte),
		.tx_start_i(tx_start),
		.busy_o(tx_busy),
		.serial_o(serial_o)
	);

endmodule

// ==== verification/flash_emu_chk.sv ====
`timescale 1ns/1ps

module flash_emu_chk (
	input  logic clk,
	input  logic reset,
	// store read port
	input  logic rd_en_i,
	input  logic rd_ack_i,
	// synchronized chip select from the spi side
	input  logic cs_active_i,
	// host load port
	input  logic load_we_i,
	input  logic load_ready_i,
	// uart handoff
	input  logic tx_start_i,
	input  logic tx_busy_i
);
	// number of failed assertions
	int fail_count = 0;

	//////////////////////////////////////////////////////////////////////
	// store read latency
	//////////////////////////////////////////////////////////////////////

	// every request is answered exactly one cycle later
	a_rd_ack_follows: assert property (@(posedge clk) disable iff (reset)
		rd_en_i |=> rd_ack_i)
	else
	begin
		fail_count++;
		$error("rd_ack did not follow rd_en by one cycle");
	end

	//////////////////////////////////////////////////////////////////////
	// host loads and log output
	//////////////////////////////////////////////////////////////////////

	// host writes land only outside a selected spi transaction
	a_load_not_critical: assert property (@(posedge clk) disable iff (reset)
		(load_we_i && load_ready_i) |-> !cs_active_i)
	else
	begin
		fail_count++;
		$error("host load accepted while chip select was active");
	end

	// a new byte only starts on an idle uart
	a_start_not_busy: assert property (@(posedge clk) disable iff (reset)
		tx_start_i |-> !tx_busy_i)
	else
	begin
		fail_count++;
		$error("uart tx_start while busy");
	end

endmodule

bind flash_emu_top flash_emu_chk chk (
	.clk(clk),
	.reset(reset),
	.rd_en_i(rd_en),
	.rd_ack_i(rd_ack),
	.cs_active_i(cs_active),
	.load_we_i(load_we_i),
	.load_ready_i(load_ready_o),
	.tx_start_i(tx_start),
	.tx_busy_i(tx_busy)
);

// ==== verification/flash_emu_tb.sv ====
`timescale 1ns/1ps

module flash_emu_tb;

	// sck half period in clk cycles
	localparam int SCK_HALF = 8;
	// short burst, a whole read fits inside one record time
	localparam int FAST_HALF = 3;
	localparam int N_TXN = 24;
	localparam int MAX_LEN = 16;
	localparam int SAT_LEN = 260;
	localparam int DEPTH = flash_emu_pkg::MEM_DEPTH;
	localparam int BYTE_CYC = 2 * SCK_HALF * flash_emu_pkg::BYTE_W;
	// four 8N1 frames back to back
	localparam int REC_CYC = flash_emu_pkg::LOG_BYTES * 10 * flash_emu_pkg::BAUD_DIV;
	// preload, all transactions and their records, doubled
	localparam int WATCHDOG_CYC = 2 * (2 * DEPTH
		+ N_TXN * ((4 + MAX_LEN) * BYTE_CYC + 3 * REC_CYC)
		+ (SAT_LEN + 40) * BYTE_CYC + 20 * REC_CYC);

	logic clk;
	logic reset;
	logic spi_cs_n;
	logic spi_sck;
	logic spi_mosi;
	logic spi_miso;
	logic spi_miso_oe;
	logic load_we;
	logic [flash_emu_pkg::MEM_AW-1:0] load_addr;
	logic [flash_emu_pkg::BYTE_W-1:0] load_data;
	logic load_ready;
	logic serial;
	logic [flash_emu_pkg::BYTE_W-1:0] drop_count;

	integer seed = 38;
	// reference copy of the store
	logic [flash_emu_pkg::BYTE_W-1:0] model [DEPTH];
	// bytes seen on serial_o
	logic [flash_emu_pkg::BYTE_W-1:0] rx_q [$];
	string test_name;
	logic [flash_emu_pkg::BYTE_W-1:0] drops_exp;

	flash_emu_top dut (
		.clk(clk),
		.reset(reset),
		.spi_cs_n_i(spi_cs_n),
		.spi_sck_i(spi_sck),
		.spi_mosi_i(spi_mosi),
		.spi_miso_o(spi_miso),
		.spi_miso_oe_o(spi_miso_oe),
		.load_we_i(load_we),
		.load_addr_i(load_addr),
		.load_data_i(load_data),
		.load_ready_o(load_ready),
		.serial_o(serial),
		.drop_count_o(drop_count)
	);

	initial
		clk = 1'b0;
	always #5 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// error handling and compares
	//////////////////////////////////////////////////////////////////////

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input logic [flash_emu_pkg::BYTE_W-1:0] exp,
		input logic [flash_emu_pkg::BYTE_W-1:0] act);
		if (act !== exp)
			stop_on_error($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_record(input string name,
		input logic [flash_emu_pkg::ADDR_W+flash_emu_pkg::LEN_W-1:0] exp,
		input logic [flash_emu_pkg::ADDR_W+flash_emu_pkg::LEN_W-1:0] act);
		if (act !== exp)
			stop_on_error($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_count(input string name, input logic [flash_emu_pkg::BYTE_W-1:0] exp,
		input logic [flash_emu_pkg::BYTE_W-1:0] act);
		if (act !== exp)
			stop_on_error($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
	endtask

	//////////////////////////////////////////////////////////////////////
	// spi master, mode 0, msb first
	//////////////////////////////////////////////////////////////////////

	// entered just after a falling clk edge with sck low
	task automatic spi_byte(input logic [7:0] mosi_byte, input int half,
		output logic [7:0] miso_byte, output logic oe_any, output logic oe_all);
		int i;
		oe_any = 1'b0;
		oe_all = 1'b1;
		for (i = 7; i >= 0; i--)
		begin
			spi_mosi = mosi_byte[i];
			repeat (half) @(negedge clk);
			// miso sampled just ahead of the rising edge
			miso_byte[i] = spi_miso;
			oe_any = oe_any | spi_miso_oe;
			oe_all = oe_all & spi_miso_oe;
			spi_sck = 1'b1;
			repeat (half) @(negedge clk);
			spi_sck = 1'b0;
		end
	endtask

	task automatic deselect(input int half);
		repeat (half) @(negedge clk);
		spi_cs_n = 1'b1;
		repeat (half) @(negedge clk);
	endtask

	task automatic spi_read(input logic [flash_emu_pkg::ADDR_W-1:0] addr, input int len,
		input int half, input logic check);
		logic [7:0] got;
		logic oe_any;
		logic oe_all;
		logic [flash_emu_pkg::MEM_AW-1:0] a;
		int k;
		spi_cs_n = 1'b0;
		repeat (2) @(negedge clk);
		spi_byte(flash_emu_pkg::CMD_READ, half, got, oe_any, oe_all);
		spi_byte(addr[23:16], half, got, oe_any, oe_all);
		spi_byte(addr[15:8], half, got, oe_any, oe_all);
		spi_byte(addr[7:0], half, got, oe_any, oe_all);
		for (k = 0; k < len; k++)
		begin
			spi_byte(8'h00, half, got, oe_any, oe_all);
			// store index wraps modulo its depth
			a = addr[flash_emu_pkg::MEM_AW-1:0] + k;
			if (check)
			begin
				check_byte(test_name, model[a], got);
				if (!oe_all)
					stop_on_error("MISO output enable dropped during READ data");
			end
		end
		deselect(half);
	endtask

	task automatic run_read_id;
		logic [7:0] got;
		logic [7:0] exp;
		logic oe_any;
		logic oe_all;
		logic [flash_emu_pkg::ADDR_W-1:0] id;
		int k;
		test_name = "read_id";
		id = flash_emu_pkg::JEDEC_ID;
		spi_cs_n = 1'b0;
		repeat (2) @(negedge clk);
		spi_byte(flash_emu_pkg::CMD_READ_ID, SCK_HALF, got, oe_any, oe_all);
		for (k = 0; k < 6; k++)
		begin
			spi_byte(8'h00, SCK_HALF, got, oe_any, oe_all);
			// three id bytes msb first, then zeros
			exp = (k < 3) ? id[8*(2-k) +: 8] : 8'h00;
			check_byte(test_name, exp, got);
			if (!oe_all)
				stop_on_error("MISO output enable dropped during READ ID");
		end
		deselect(SCK_HALF);
		expect_no_record();
	endtask

	task automatic run_unknown;
		logic [7:0] cmd;
		logic [7:0] got;
		logic oe_any;
		logic oe_all;
		logic seen;
		int k;
		test_name = "unknown_cmd";
		cmd = $random(seed);
		while (cmd == flash_emu_pkg::CMD_READ || cmd == flash_emu_pkg::CMD_READ_ID)
			cmd = $random(seed);
		spi_cs_n = 1'b0;
		repeat (2) @(negedge clk);
		spi_byte(cmd, SCK_HALF, got, oe_any, oe_all);
		seen = oe_any;
		for (k = 0; k < 4; k++)
		begin
			spi_byte($random(seed), SCK_HALF, got, oe_any, oe_all);
			seen = seen | oe_any;
		end
		deselect(SCK_HALF);
		if (seen)
			stop_on_error("MISO output enable went high during an unknown command");
		expect_no_record();
	endtask

	//////////////////////////////////////////////////////////////////////
	// load port and log records
	//////////////////////////////////////////////////////////////////////

	task automatic load_byte(input logic [flash_emu_pkg::MEM_AW-1:0] addr,
		input logic [flash_emu_pkg::BYTE_W-1:0] data);
		int wait_cyc;
		load_addr = addr;
		load_data = data;
		load_we = 1'b1;
		wait_cyc = 0;
		// ready seen here means the next rising edge takes the write
		while (load_ready !== 1'b1)
		begin
			@(negedge clk);
			wait_cyc++;
			if (wait_cyc > 64 * BYTE_CYC)
				stop_on_error("load port never became ready");
		end
		@(negedge clk);
		load_we = 1'b0;
		model[addr] = data;
	endtask

	task automatic expect_record(input logic [flash_emu_pkg::ADDR_W-1:0] addr, input int len);
		logic [flash_emu_pkg::ADDR_W+flash_emu_pkg::LEN_W-1:0] act;
		logic [flash_emu_pkg::LEN_W-1:0] exp_len;
		int wait_cyc;
		int n;
		wait_cyc = 0;
		while (rx_q.size() < flash_emu_pkg::LOG_BYTES)
		begin
			@(negedge clk);
			wait_cyc++;
			if (wait_cyc > 2 * REC_CYC)
				stop_on_error("no log record arrived on serial_o");
		end
		act = '0;
		for (n = 0; n < flash_emu_pkg::LOG_BYTES; n++)
			act = (act << 8) | rx_q.pop_front();
		// length saturates at all ones
		exp_len = (len >= (1 << flash_emu_pkg::LEN_W)) ? '1 : len;
		check_record(test_name, {addr, exp_len}, act);
	endtask

	task automatic expect_no_record;
		repeat (REC_CYC + 4 * flash_emu_pkg::BAUD_DIV) @(negedge clk);
		if (rx_q.size() != 0)
			stop_on_error("unexpected log record on serial_o");
	endtask

	// 8N1 receiver, samples near mid bit
	task automatic receive_byte;
		logic [7:0] b;
		int i;
		repeat (flash_emu_pkg::BAUD_DIV / 2) @(negedge clk);
		if (serial !== 1'b0)
			stop_on_error("start bit on serial_o too short");
		for (i = 0; i < 8; i++)
		begin
			repeat (flash_emu_pkg::BAUD_DIV) @(negedge clk);
			b[i] = serial;
		end
		repeat (flash_emu_pkg::BAUD_DIV) @(negedge clk);
		if (serial !== 1'b1)
			stop_on_error("missing stop bit on serial_o");
		rx_q.push_back(b);
	endtask

	always @(negedge clk)
	begin
		if (!reset && serial === 1'b0)
			receive_byte();
	end

	// bound checker failures end the run right away
	always @(negedge clk)
	begin
		if (dut.chk.fail_count != 0)
			stop_on_error("protocol assertion failed in the bound checker");
	end

	initial
	begin
		repeat (WATCHDOG_CYC) @(posedge clk);
		stop_on_error("watchdog expired before the tests finished");
	end

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [flash_emu_pkg::ADDR_W-1:0] addr;
		logic [flash_emu_pkg::MEM_AW-1:0] la;
		logic [flash_emu_pkg::BYTE_W-1:0] ld;
		int len;
		int kind;
		int t;
		reset = 1'b1;
		spi_cs_n = 1'b1;
		spi_sck = 1'b0;
		spi_mosi = 1'b0;
		load_we = 1'b0;
		load_addr = '0;
		load_data = '0;
		drops_exp = '0;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		test_name = "reset";
		check_count(test_name, 8'h00, drop_count);
		if (serial !== 1'b1)
			stop_on_error("serial_o not idle high after reset");

		// random preload of the whole store
		for (t = 0; t < DEPTH; t++)
			load_byte(t, $random(seed));

		run_read_id();
		run_unknown();
		// read across the top of the store
		test_name = "read_wrap";
		spi_read(24'h000ffa, 12, SCK_HALF, 1'b1);
		expect_record(24'h000ffa, 12);

		for (t = 0; t < N_TXN; t++)
		begin
			kind = $random(seed) & 7;
			if (kind == 0)
				run_read_id();
			else if (kind == 1)
				run_unknown();
			else
			begin
				test_name = "read_random";
				addr = $random(seed) & (DEPTH - 1);
				len = 1 + ($random(seed) & (MAX_LEN - 1));
				spi_read(addr, len, SCK_HALF, 1'b1);
				expect_record(addr, len);
			end
		end

		test_name = "read_saturate";
		addr = $random(seed) & (DEPTH - 1);
		spi_read(addr, SAT_LEN, SCK_HALF, 1'b1);
		expect_record(addr, SAT_LEN);

		// second read ends while the first record is on the wire
		test_name = "drop";
		addr = $random(seed) & (DEPTH - 1);
		spi_read(addr, 2, SCK_HALF, 1'b1);
		spi_read($random(seed) & (DEPTH - 1), 1, FAST_HALF, 1'b0);
		drops_exp = drops_exp + 1'b1;
		expect_record(addr, 2);
		expect_no_record();
		check_count(test_name, drops_exp, drop_count);

		// host load stalls behind an active read
		test_name = "load_stall";
		addr = $random(seed) & (DEPTH - 1);
		la = addr[flash_emu_pkg::MEM_AW-1:0] + 12'h800;
		ld = $random(seed);
		fork
			spi_read(addr, 4, SCK_HALF, 1'b1);
			begin
				repeat (40) @(negedge clk);
				if (load_ready !== 1'b0)
					stop_on_error("load_ready_o high while chip select is low");
				load_byte(la, ld);
			end
		join
		expect_record(addr, 4);
		test_name = "load_readback";
		spi_read({12'h000, la}, 1, SCK_HALF, 1'b1);
		expect_record({12'h000, la}, 1);

		test_name = "final_drops";
		check_count(test_name, drops_exp, drop_count);
		if (dut.chk.fail_count == 0)
		begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
		else
			stop_on_error("protocol assertion failures were recorded");
	end

endmodule

// ==== sources.f ====
design/flash_emu_pkg.sv
design/spi_device.sv
design/spi_flash.sv
design/flash_mem.sv
design/log_serializer.sv
design/uart_tx.sv
design/flash_emu_top.sv
verification/flash_emu_chk.sv
verification/flash_emu_tb.sv

// ==== Bender.yml ====
package:
  name: flash_emu

sources:
  - files:
      - design/flash_emu_pkg.sv
      - design/spi_device.sv
      - design/spi_flash.sv
      - design/flash_mem.sv
      - design/log_serializer.sv
      - design/uart_tx.sv
      - design/flash_emu_top.sv
  - target: test
    files:
      - verification/flash_emu_chk.sv
      - verification/flash_emu_tb.sv
